//--- source/swu_pkg.sv
package swu_pkg;

   //////////////////////////////////////////////////
   // element indices
   //////////////////////////////////////////////////

   // frame-relative index width for frames of about one million elements
   localparam int IDX_W = 20;

   // channel-fold element index counted from the start of the frame
   typedef logic [IDX_W-1:0] idx_t;

   //////////////////////////////////////////////////
   // read control state
   //////////////////////////////////////////////////

   // RUN      both writer and reader busy in the frame
   // WR_DONE  frame fully written, reader still draining windows
   // RD_DONE  last window element accepted, writer still filling
   // RESTART  single cycle that clears all frame counters
   typedef enum logic [1:0] {
      RUN     = 2'd0,
      WR_DONE = 2'd1,
      RD_DONE = 2'd2,
      RESTART = 2'd3
   } swu_state_e;

endpackage

//--- source/swu_fill_tracker.sv
`timescale 1ns/1ps

module swu_fill_tracker #(
   parameter int IFM_W   = 7,
   parameter int IFM_H   = 6,
   parameter int CH_FOLD = 2,
   parameter int DEPTH   = 42
) (
   input  logic            clk,
   input  logic            resetn,
   input  logic            in_valid_i,
   input  swu_pkg::idx_t   oldest_idx_i,
   input  logic            frame_clear_i,
   input  logic            wr_hold_i,
   output logic            in_ready_o,
   output logic            wr_fire_o,
   output swu_pkg::idx_t   wr_count_o,
   output logic            wr_frame_done_o
);

   // elements in one full input frame
   localparam int FRAME_LEN = IFM_H * IFM_W * CH_FOLD;

   // one extra bit so that oldest plus depth cannot overflow
   logic [swu_pkg::IDX_W:0] space_limit;
   logic                    has_space;

   //////////////////////////////////////////////////
   // space rule
   //////////////////////////////////////////////////

   // equivalent to wr_count - oldest < DEPTH, but also holds once the
   // reader has moved its oldest row past the write position
   assign space_limit = {1'b0, oldest_idx_i} + (swu_pkg::IDX_W + 1)'(DEPTH);
   assign has_space   = {1'b0, wr_count_o} < space_limit;

   assign wr_frame_done_o = wr_count_o == swu_pkg::idx_t'(FRAME_LEN);

   // no new frame data until the restart cycle has cleared the counters
   assign in_ready_o = !wr_hold_i && !wr_frame_done_o && has_space;
   assign wr_fire_o  = in_valid_i && in_ready_o;

   //////////////////////////////////////////////////
   // element counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_clear_i) begin
         wr_count_o <= '0;
      end else if (wr_fire_o) begin
         wr_count_o <= wr_count_o + 1'b1;
      end
   end

endmodule

//--- source/swu_line_buffer.sv
`timescale 1ns/1ps

module swu_line_buffer #(
   parameter int DEPTH  = 42,
   parameter int ELEM_W = 16
) (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic                     wr_fire_i,
   input  logic [ELEM_W-1:0]        wr_data_i,
   input  logic                     rd_en_i,
   input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
   input  logic                     frame_clear_i,
   output logic [ELEM_W-1:0]        rd_data_o
);

   localparam int AW = $clog2(DEPTH);

   // KERNEL_H image rows where element i of the frame lives at i mod DEPTH
   logic [ELEM_W-1:0] mem [DEPTH];
   logic [AW-1:0]     wr_ptr;

   // write pointer follows the frame index modulo DEPTH
   always_ff @(posedge clk) begin
      if (!resetn || frame_clear_i) begin
         wr_ptr <= '0;
      end else if (wr_fire_i) begin
         if (wr_ptr == AW'(DEPTH - 1)) begin
            wr_ptr <= '0;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // output register holds its value while the consumer stalls
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

//--- source/swu_window_counter.sv
`timescale 1ns/1ps

module swu_window_counter #(
   parameter int IFM_W    = 7,
   parameter int CH_FOLD  = 2,
   parameter int KERNEL_H = 3,
   parameter int KERNEL_W = 3,
   parameter int STRIDE   = 2,
   parameter int OFM_W    = 3,
   parameter int OFM_H    = 2,
   parameter int DEPTH    = 42
) (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic                     rd_en_i,
   input  logic                     frame_clear_i,
   output swu_pkg::idx_t            need_idx_o,
   output swu_pkg::idx_t            oldest_idx_o,
   output logic [$clog2(DEPTH)-1:0] rd_addr_o,
   output logic                     win_last_o
);

   localparam int AW        = $clog2(DEPTH);
   localparam int ROW_LEN   = IFM_W * CH_FOLD;
   localparam int COL_STEP  = STRIDE * CH_FOLD;
   localparam int ROW_STEP  = STRIDE * ROW_LEN;
   localparam int BASE_STEP = ROW_STEP % DEPTH;
   localparam int CH_W      = $clog2(CH_FOLD + 1);
   localparam int KW_W      = $clog2(KERNEL_W + 1);
   localparam int KH_W      = $clog2(KERNEL_H + 1);
   localparam int COL_W     = $clog2(OFM_W + 1);
   localparam int ROW_W     = $clog2(OFM_H + 1);

   logic [CH_W-1:0]  ch;
   logic [KW_W-1:0]  kw;
   logic [KH_W-1:0]  kh;
   logic [COL_W-1:0] ofm_col;
   logic [ROW_W-1:0] ofm_row;

   // col_off is ofm_col * STRIDE * CH_FOLD, rd_base is oldest_idx mod DEPTH
   swu_pkg::idx_t    col_off;
   swu_pkg::idx_t    win_off;
   swu_pkg::idx_t    buf_off;
   logic [AW-1:0]    rd_base;
   logic [AW:0]      base_sum;
   logic [AW:0]      addr_sum;
   logic             ch_wrap;
   logic             kw_wrap;
   logic             kh_wrap;
   logic             col_wrap;

   assign ch_wrap  = ch == CH_W'(CH_FOLD - 1);
   assign kw_wrap  = kw == KW_W'(KERNEL_W - 1);
   assign kh_wrap  = kh == KH_W'(KERNEL_H - 1);
   assign col_wrap = ofm_col == COL_W'(OFM_W - 1);

   assign win_last_o = ch_wrap && kw_wrap && kh_wrap && col_wrap
                       && ofm_row == ROW_W'(OFM_H - 1);

   //////////////////////////////////////////////////
   // frame index and buffer address
   //////////////////////////////////////////////////

   // offset inside the window, kernel row major then column then fold
   assign win_off = swu_pkg::idx_t'(kh * ROW_LEN + kw * CH_FOLD + ch);
   assign buf_off = col_off + win_off;

   assign oldest_idx_o = swu_pkg::idx_t'(ofm_row * ROW_STEP);
   assign need_idx_o   = oldest_idx_o + buf_off;

   // buf_off stays below DEPTH, so one subtraction is enough
   assign addr_sum  = {1'b0, rd_base} + {1'b0, buf_off[AW-1:0]};
   assign rd_addr_o = (addr_sum >= (AW + 1)'(DEPTH)) ?
                      AW'(addr_sum - (AW + 1)'(DEPTH)) : addr_sum[AW-1:0];

   assign base_sum = {1'b0, rd_base} + (AW + 1)'(BASE_STEP);

   //////////////////////////////////////////////////
   // position counters
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_clear_i) begin
         ch      <= '0;
         kw      <= '0;
         kh      <= '0;
         ofm_col <= '0;
         ofm_row <= '0;
         col_off <= '0;
         rd_base <= '0;
      end else if (rd_en_i) begin
         if (!ch_wrap) begin
            ch <= ch + 1'b1;
         end else begin
            ch <= '0;
            if (!kw_wrap) begin
               kw <= kw + 1'b1;
            end else begin
               kw <= '0;
               if (!kh_wrap) begin
                  kh <= kh + 1'b1;
               end else begin
                  kh <= '0;
                  if (!col_wrap) begin
                     ofm_col <= ofm_col + 1'b1;
                     col_off <= col_off + swu_pkg::idx_t'(COL_STEP);
                  end else begin
                     ofm_col <= '0;
                     col_off <= '0;
                     // after the final window ofm_row rests at OFM_H, which
                     // pushes oldest_idx forward and frees the writer
                     ofm_row <= ofm_row + 1'b1;
                     rd_base <= (base_sum >= (AW + 1)'(DEPTH)) ?
                                AW'(base_sum - (AW + 1)'(DEPTH)) : base_sum[AW-1:0];
                  end
               end
            end
         end
      end
   end

endmodule

//--- source/swu_read_fsm.sv
`timescale 1ns/1ps

module swu_read_fsm (
   input  logic          clk,
   input  logic          resetn,
   input  swu_pkg::idx_t need_idx_i,
   input  swu_pkg::idx_t wr_count_i,
   input  logic          win_last_i,
   input  logic          wr_frame_done_i,
   input  logic          out_ready_i,
   output logic          rd_en_o,
   output logic          out_valid_o,
   output logic          wr_hold_o,
   output logic          frame_clear_o
);

   swu_pkg::swu_state_e state;

   // the final window element has been issued to the buffer
   logic last_rd;
   logic rd_active;
   logic out_free;
   logic last_accept;

   //////////////////////////////////////////////////
   // read issue
   //////////////////////////////////////////////////

   assign rd_active = state == swu_pkg::RUN || state == swu_pkg::WR_DONE;

   // output register empty, or emptied by the consumer this cycle
   assign out_free = !out_valid_o || out_ready_i;

   // element must already be in the buffer before it is read
   assign rd_en_o = rd_active && !last_rd && (need_idx_i < wr_count_i) && out_free;

   // only one element in flight, so this is the last one of the frame
   assign last_accept = last_rd && out_valid_o && out_ready_i;

   assign wr_hold_o     = state == swu_pkg::WR_DONE || state == swu_pkg::RESTART;
   assign frame_clear_o = state == swu_pkg::RESTART;

   always_ff @(posedge clk) begin
      if (!resetn || frame_clear_o) begin
         out_valid_o <= 1'b0;
         last_rd     <= 1'b0;
      end else begin
         if (rd_en_o) begin
            out_valid_o <= 1'b1;
         end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
         end
         if (rd_en_o && win_last_i) begin
            last_rd <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // frame sequencing
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= swu_pkg::RUN;
      end else begin
         case (state)
            swu_pkg::RUN: begin
               if (last_accept && wr_frame_done_i) begin
                  state <= swu_pkg::RESTART;
               end else if (last_accept) begin
                  state <= swu_pkg::RD_DONE;
               end else if (wr_frame_done_i) begin
                  state <= swu_pkg::WR_DONE;
               end
            end
            swu_pkg::WR_DONE: begin
               if (last_accept) begin
                  state <= swu_pkg::RESTART;
               end
            end
            swu_pkg::RD_DONE: begin
               // writer still has leftover rows and columns to take in
               if (wr_frame_done_i) begin
                  state <= swu_pkg::RESTART;
               end
            end
            default: begin
               state <= swu_pkg::RUN;
            end
         endcase
      end
   end

endmodule

//--- source/swu_top.sv
`timescale 1ns/1ps

module swu_top #(
   parameter int IFM_W    = 7,
   parameter int IFM_H    = 6,
   parameter int CH_FOLD  = 2,
   parameter int KERNEL_H = 3,
   parameter int KERNEL_W = 3,
   parameter int STRIDE   = 2,
   parameter int ELEM_W   = 16
) (
   input  logic              clk,
   input  logic              resetn,
   input  logic [ELEM_W-1:0] in_data_i,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   output logic [ELEM_W-1:0] out_data_o,
   output logic              out_valid_o,
   input  logic              out_ready_i
);

   // leftover rows and columns beyond the last full stride are dropped
   localparam int OFM_W = (IFM_W - KERNEL_W) / STRIDE + 1;
   localparam int OFM_H = (IFM_H - KERNEL_H) / STRIDE + 1;
   localparam int DEPTH = KERNEL_H * IFM_W * CH_FOLD;

   logic                     wr_fire;
   logic                     wr_frame_done;
   logic                     wr_hold;
   logic                     win_last;
   logic                     rd_en;
   logic                     frame_clear;
   swu_pkg::idx_t            wr_count;
   swu_pkg::idx_t            need_idx;
   swu_pkg::idx_t            oldest_idx;
   logic [$clog2(DEPTH)-1:0] rd_addr;

   //////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////

   swu_fill_tracker #(
      .IFM_W   (IFM_W),
      .IFM_H   (IFM_H),
      .CH_FOLD (CH_FOLD),
      .DEPTH   (DEPTH)
   ) i_fill_tracker (
      .clk             (clk),
      .resetn          (resetn),
      .in_valid_i      (in_valid_i),
      .oldest_idx_i    (oldest_idx),
      .frame_clear_i   (frame_clear),
      .wr_hold_i       (wr_hold),
      .in_ready_o      (in_ready_o),
      .wr_fire_o       (wr_fire),
      .wr_count_o      (wr_count),
      .wr_frame_done_o (wr_frame_done)
   );

   swu_line_buffer #(
      .DEPTH  (DEPTH),
      .ELEM_W (ELEM_W)
   ) i_line_buffer (
      .clk           (clk),
      .resetn        (resetn),
      .wr_fire_i     (wr_fire),
      .wr_data_i     (in_data_i),
      .rd_en_i       (rd_en),
      .rd_addr_i     (rd_addr),
      .frame_clear_i (frame_clear),
      .rd_data_o     (out_data_o)
   );

   //////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////

   swu_window_counter #(
      .IFM_W    (IFM_W),
      .CH_FOLD  (CH_FOLD),
      .KERNEL_H (KERNEL_H),
      .KERNEL_W (KERNEL_W),
      .STRIDE   (STRIDE),
      .OFM_W    (OFM_W),
      .OFM_H    (OFM_H),
      .DEPTH    (DEPTH)
   ) i_window_counter (
      .clk           (clk),
      .resetn        (resetn),
      .rd_en_i       (rd_en),
      .frame_clear_i (frame_clear),
      .need_idx_o    (need_idx),
      .oldest_idx_o  (oldest_idx),
      .rd_addr_o     (rd_addr),
      .win_last_o    (win_last)
   );

   swu_read_fsm i_read_fsm (
      .clk             (clk),
      .resetn          (resetn),
      .need_idx_i      (need_idx),
      .wr_count_i      (wr_count),
      .win_last_i      (win_last),
      .wr_frame_done_i (wr_frame_done),
      .out_ready_i     (out_ready_i),
      .rd_en_o         (rd_en),
      .out_valid_o     (out_valid_o),
      .wr_hold_o       (wr_hold),
      .frame_clear_o   (frame_clear)
   );

endmodule

//--- sim/tb_swu.sv
`timescale 1ns/1ps

module tb_swu;

   localparam int IFM_W    = 7;
   localparam int IFM_H    = 6;
   localparam int CH_FOLD  = 2;
   localparam int KERNEL_H = 3;
   localparam int KERNEL_W = 3;
   localparam int STRIDE   = 2;
   localparam int ELEM_W   = 16;

   localparam int OFM_W     = (IFM_W - KERNEL_W) / STRIDE + 1;
   localparam int OFM_H     = (IFM_H - KERNEL_H) / STRIDE + 1;
   localparam int DEPTH     = KERNEL_H * IFM_W * CH_FOLD;
   localparam int FRAME_LEN = IFM_H * IFM_W * CH_FOLD;
   localparam int WIN_LEN   = KERNEL_H * KERNEL_W * CH_FOLD;
   localparam int OUT_LEN   = OFM_H * OFM_W * WIN_LEN;
   // one frame each for tests 2 to 4 and three for test 5
   localparam int N_FRAMES  = 6;
   localparam int WATCHDOG_CYCLES = 40 * N_FRAMES * (FRAME_LEN + OUT_LEN);

   logic              clk;
   logic              resetn;
   logic [ELEM_W-1:0] in_data_i;
   logic              in_valid_i;
   logic              in_ready_o;
   logic [ELEM_W-1:0] out_data_o;
   logic              out_valid_o;
   logic              out_ready_i;

   int                seed;
   int                stall_pct;
   int                err_cnt;
   int                test_cnt;
   int                test_fail;
   int                frames_sent;
   int                in_frame;
   int                in_cnt;
   int                out_frame;
   int                out_cnt;
   int                exp_idx [OUT_LEN];
   int                min_left [OUT_LEN];
   logic              stalled;
   logic [ELEM_W-1:0] held_data;

   swu_top #(
      .IFM_W    (IFM_W),
      .IFM_H    (IFM_H),
      .CH_FOLD  (CH_FOLD),
      .KERNEL_H (KERNEL_H),
      .KERNEL_W (KERNEL_W),
      .STRIDE   (STRIDE),
      .ELEM_W   (ELEM_W)
   ) i_dut (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   always #5 clk = ~clk;

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////

   // frame index of output position p in window order row, col, kh, kw, ch
   function automatic int window_index(input int p);
      int ch;
      int kw;
      int kh;
      int col;
      int row;
      ch  = p % CH_FOLD;
      kw  = (p / CH_FOLD) % KERNEL_W;
      kh  = (p / (CH_FOLD * KERNEL_W)) % KERNEL_H;
      col = (p / WIN_LEN) % OFM_W;
      row = p / (WIN_LEN * OFM_W);
      return (row * STRIDE + kh) * IFM_W * CH_FOLD + (col * STRIDE + kw) * CH_FOLD + ch;
   endfunction

   // frame number in the top four bits and frame index below
   function automatic logic [ELEM_W-1:0] elem_value(input int frame, input int idx);
      return ELEM_W'((frame % 16) * 4096 + idx);
   endfunction

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   // in_ready_o only moves on the rising edge, so the falling edge sees its settled value
   task automatic send_frame(input int gap);
      int f;
      f = frames_sent;
      frames_sent++;
      for (int w = 0; w < FRAME_LEN; w++) begin
         while (gap > 0 && ({$random(seed)} % 100) < gap) begin
            @(negedge clk);
            in_valid_i = 1'b0;
         end
         @(negedge clk);
         in_valid_i = 1'b1;
         in_data_i  = elem_value(f, w);
         while (!in_ready_o) begin
            @(negedge clk);
         end
      end
   endtask

   task automatic idle_input();
      @(negedge clk);
      in_valid_i = 1'b0;
   endtask

   task automatic wait_frames(input int target);
      while (out_frame < target) begin
         @(negedge clk);
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         test_fail++;
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
      end
   endtask

   // random back-pressure with stall_pct percent of the cycles not ready
   always @(negedge clk) begin
      out_ready_i = resetn && (({$random(seed)} % 100) >= stall_pct);
   end

   //////////////////////////////////////////////////
   // monitor
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      int p;
      if (resetn) begin
         if (stalled) begin
            assert (out_valid_o) else begin
               $display("Error at %0t: out_valid_o got %b, expected 1", $time, out_valid_o);
               err_cnt++;
            end
            assert (out_data_o == held_data) else begin
               $display("Error at %0t: out_data_o got %h, expected %h", $time,
                        out_data_o, held_data);
               err_cnt++;
            end
         end
         stalled   = out_valid_o && !out_ready_i;
         held_data = out_data_o;

         // overwritten slot holds element in_cnt - DEPTH, which must be consumed
         if (in_valid_i && in_ready_o) begin
            p = out_cnt + int'(out_valid_o);
            if (in_frame == out_frame && p < OUT_LEN) begin
               assert (in_cnt < min_left[p] + DEPTH) else begin
                  $display("input %0d of frame %0d taken at %0t while element %0d is unread",
                           in_cnt, in_frame, $time, min_left[p]);
                  err_cnt++;
               end
            end
            in_cnt++;
            if (in_cnt == FRAME_LEN) begin
               in_cnt = 0;
               in_frame++;
            end
         end

         if (out_valid_o && out_ready_i) begin
            assert (out_frame < frames_sent) else begin
               $display("extra output at %0t after the last frame ended", $time);
               err_cnt++;
            end
            assert (int'(out_data_o[ELEM_W-1 -: 4]) == out_frame % 16) else begin
               $display("Error at %0t: out_data_o frame field got %0d, expected %0d", $time,
                        out_data_o[ELEM_W-1 -: 4], out_frame % 16);
               err_cnt++;
            end
            assert (out_data_o == elem_value(out_frame, exp_idx[out_cnt])) else begin
               $display("Error at %0t: out_data_o got %h, expected %h", $time,
                        out_data_o, elem_value(out_frame, exp_idx[out_cnt]));
               err_cnt++;
            end
            out_cnt++;
            if (out_cnt == OUT_LEN) begin
               out_cnt = 0;
               out_frame++;
            end
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles, the DUT stopped moving data", WATCHDOG_CYCLES);
      $display("sim failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      int errs;
      seed        = 32'h30eb_e768;
      clk         = 1'b0;
      resetn      = 1'b0;
      in_data_i   = '0;
      in_valid_i  = 1'b0;
      out_ready_i = 1'b0;
      stall_pct   = 0;
      err_cnt     = 0;
      test_cnt    = 0;
      test_fail   = 0;
      frames_sent = 0;
      in_frame    = 0;
      in_cnt      = 0;
      out_frame   = 0;
      out_cnt     = 0;
      stalled     = 1'b0;
      held_data   = '0;

      for (int p = 0; p < OUT_LEN; p++) begin
         exp_idx[p] = window_index(p);
      end
      // smallest frame index still to be read from position p on
      min_left[OUT_LEN-1] = exp_idx[OUT_LEN-1];
      for (int p = OUT_LEN - 2; p >= 0; p--) begin
         min_left[p] = (exp_idx[p] < min_left[p+1]) ? exp_idx[p] : min_left[p+1];
      end

      repeat (8) @(negedge clk);
      resetn = 1'b1;

      errs = err_cnt;
      @(negedge clk);
      assert (!out_valid_o) else begin
         $display("Error at %0t: out_valid_o got %b, expected 0", $time, out_valid_o);
         err_cnt++;
      end
      assert (in_ready_o) else begin
         $display("Error at %0t: in_ready_o got %b, expected 1", $time, in_ready_o);
         err_cnt++;
      end
      end_test("reset state", errs);

      errs = err_cnt;
      send_frame(0);
      idle_input();
      wait_frames(1);
      end_test("full rate frame", errs);

      errs = err_cnt;
      stall_pct = 40;
      send_frame(0);
      idle_input();
      wait_frames(2);
      end_test("output stalls", errs);

      errs = err_cnt;
      stall_pct = 0;
      send_frame(40);
      idle_input();
      wait_frames(3);
      end_test("input gaps", errs);

      errs = err_cnt;
      stall_pct = 30;
      send_frame(20);
      send_frame(20);
      send_frame(20);
      idle_input();
      wait_frames(6);
      // nothing may follow the last element of the last frame
      repeat (WIN_LEN) @(negedge clk);
      assert (!out_valid_o) else begin
         $display("Error at %0t: out_valid_o got %b, expected 0", $time, out_valid_o);
         err_cnt++;
      end
      end_test("back-to-back frames", errs);

      $display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- swu_top.f
source/swu_pkg.sv
source/swu_fill_tracker.sv
source/swu_line_buffer.sv
source/swu_window_counter.sv
source/swu_read_fsm.sv
source/swu_top.sv
sim/tb_swu.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_swu
FILELIST  = swu_top.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
